// ==== list.f ====
src/tcb_pkg.sv
src/tcb_lib_riscv2memory.sv
src/tcb_mal_guard.sv
src/tcb_mem_sram.sv
src/tcb_riscv_mem_top.sv
tests/tcb_clk_gen.sv
tests/tcb_riscv_mem_props.sv
tests/tcb_riscv_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the load/store memory subsystem

VERILATOR ?= verilator
TOP       := tcb_riscv_mem_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert
SIM_FLAGS := --binary -j 0
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status comes from the search for the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tcb_patterns.hex ====
// wen uns ndn siz adr wdt exp_rdt exp_sts, widths in hex digits 1 1 1 1 3 8 8 1
// siz 0 byte 1 half 2 word 3 dbl, ndn 1 big, sts 1 misaligned, all ones ends the list
1_0_0_2_000_11223344_00000000_0
1_0_0_1_002_0000AABB_00000000_0
1_0_0_0_001_123456CC_00000000_0
1_0_0_0_007_000000EE_00000000_0
0_0_0_2_000_00000000_AABBCC44_0
0_0_0_2_004_00000000_EE000000_0
1_0_1_2_008_11223344_00000000_0
0_0_1_2_008_00000000_11223344_0
0_0_0_2_008_00000000_44332211_0
1_0_1_1_00E_0000A1B2_00000000_0
0_0_0_2_00C_00000000_B2A10000_0
0_1_1_1_00E_00000000_0000A1B2_0
1_0_0_2_010_01020304_00000000_0
0_0_1_2_010_00000000_04030201_0
0_0_0_0_001_00000000_FFFFFFCC_0
0_1_0_0_001_00000000_000000CC_0
0_0_0_0_000_00000000_00000044_0
0_0_0_1_002_00000000_FFFFAABB_0
0_0_0_1_000_00000000_FFFFCC44_0
0_1_0_1_000_00000000_0000CC44_0
0_0_1_1_00E_00000000_FFFFA1B2_0
0_0_1_0_007_00000000_FFFFFFEE_0
1_0_0_1_001_0000DEAD_00000000_1
1_0_0_2_002_DEADBEEF_00000000_1
1_0_0_3_000_DEADBEEF_00000000_1
1_0_1_2_005_DEADBEEF_00000000_1
0_0_0_1_003_00000000_00000000_1
0_0_1_3_004_00000000_00000000_1
0_0_0_2_000_00000000_AABBCC44_0
0_0_0_2_004_00000000_EE000000_0
1_0_0_2_020_CAFE0001_00000000_0
0_0_0_2_00C_00000000_B2A10000_0
1_0_0_2_024_CAFE0002_00000000_0
0_0_0_2_020_00000000_CAFE0001_0
1_0_0_1_028_00001234_00000000_0
0_0_0_2_024_00000000_CAFE0002_0
1_0_0_0_02B_00000080_00000000_0
0_0_0_2_028_00000000_80001234_0
0_0_0_0_02B_00000000_FFFFFF80_0
F_F_F_F_FFF_FFFFFFFF_FFFFFFFF_F

// ==== tests/tcb_riscv_mem_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the load/store memory subsystem
// reads request/response records from the pattern file, issues one
// request per cycle and grades each response one cycle later
//////////////////////////////////////////////////////////////////////

module tcb_riscv_mem_tb;

  // record, hex digits: wen uns ndn siz adr(3) wdt(8) rdt(8) sts
  localparam int unsigned rec_w   = 96;
  // room for the pattern list, also the loop bound
  localparam int unsigned max_pat = 128;
  // all ones closes the list
  localparam logic [rec_w-1:0] end_rec = '1;

  logic                      sub;
  logic                      arst_n;
  logic                      vld;
  logic                      wen;
  logic                      uns;
  tcb_pkg::ndn_t             ndn;
  tcb_pkg::siz_t             siz;
  logic [tcb_pkg::adr_w-1:0] adr;
  logic [tcb_pkg::dat_w-1:0] wdt;
  logic [tcb_pkg::dat_w-1:0] rdt;
  tcb_pkg::sts_t             sts;

  logic [rec_w-1:0] pat [max_pat];
  int unsigned      err_cnt;
  int unsigned      test_cnt;
  int unsigned      prop_cnt;

  tcb_clk_gen i_clk_gen (
    .sub (sub)
  );

  tcb_riscv_mem_top i_tcb_riscv_mem_top (
    .sub    (sub),
    .arst_n (arst_n),
    .vld    (vld),
    .wen    (wen),
    .uns    (uns),
    .ndn    (ndn),
    .siz    (siz),
    .adr    (adr),
    .wdt    (wdt),
    .rdt    (rdt),
    .sts    (sts)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // one record onto the request port
  task automatic send_request(input logic [rec_w-1:0] rec);
    vld <= 1'b1;
    wen <= rec[92];
    uns <= rec[88];
    ndn <= tcb_pkg::ndn_t'(rec[84]);
    siz <= tcb_pkg::siz_t'(rec[81:80]);
    adr <= rec[79:68];
    wdt <= rec[67:36];
  endtask

  // bus idle after the last record
  task automatic park_bus();
    vld <= 1'b0;
    wen <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_rdt(input logic [tcb_pkg::dat_w-1:0] got,
                           input logic [tcb_pkg::dat_w-1:0] exp);
    if (got !== exp) begin
      $display("ERR rdt got %h exp %h", got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_sts(input tcb_pkg::sts_t got, input tcb_pkg::sts_t exp);
    if (got !== exp) begin
      $display("ERR sts got %h exp %h", got, exp);
      err_cnt++;
    end
  endtask

  // status always, read data only for aligned reads
  task automatic grade_response(input logic [rec_w-1:0] rec, input int unsigned idx);
    int unsigned   err_before;
    tcb_pkg::sts_t exp_sts;
    err_before = err_cnt;
    exp_sts    = tcb_pkg::sts_t'(rec[0]);
    check_sts(sts, exp_sts);
    if (!rec[92] && exp_sts == tcb_pkg::sts_ok) begin
      check_rdt(rdt, rec[35:4]);
    end
    test_cnt++;
    $display("test %0d %s siz %0d ndn %0d adr %h %s", idx, rec[92] ? "wr" : "rd",
             rec[81:80], rec[84], rec[79:68], (err_cnt == err_before) ? "ok" : "bad");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned      idx;
    bit               done;
    logic [rec_w-1:0] prev;
    arst_n   <= 1'b0;
    vld      <= 1'b0;
    wen      <= 1'b0;
    uns      <= 1'b0;
    ndn      <= tcb_pkg::ndn_little;
    siz      <= tcb_pkg::siz_byte;
    adr      <= '0;
    wdt      <= '0;
    err_cnt  = 0;
    test_cnt = 0;
    // zero fill, so a missing end record runs into the bound
    for (int j = 0; j < max_pat; j++) begin
      pat[j] = '0;
    end
    $readmemh("tests/tcb_patterns.hex", pat);

    repeat (10) @(posedge sub);
    arst_n <= 1'b1;

    idx  = 0;
    done = 1'b0;
    prev = '0;
    // drive on the rising edge, grade the previous record at the falling edge
    while (!done && idx < max_pat) begin
      @(posedge sub);
      if (pat[idx] == end_rec) begin
        park_bus();
        done = 1'b1;
      end else begin
        send_request(pat[idx]);
      end
      @(negedge sub);
      if (idx > 0) begin
        grade_response(prev, idx - 1);
      end
      prev = pat[idx];
      idx++;
    end

    if (!done) begin
      $display("timeout, no end record within %0d pattern entries", max_pat);
      err_cnt++;
    end

    prop_cnt = i_tcb_riscv_mem_top.i_mem_props.fail_cnt;
    $display("tests %0d  errors %0d  assertion failures %0d", test_cnt, err_cnt, prop_cnt);
    if (err_cnt == 0 && prop_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/tcb_riscv_mem_props.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent checks on the converter and the misalignment guard
// bound into the top level, where request, guard strobe and status meet
// misalignment is judged from size and address, not from mal
//////////////////////////////////////////////////////////////////////

module tcb_riscv_mem_props (
  input logic                      sub,
  input logic                      arst_n,
  input logic                      mem_vld_raw,
  input tcb_pkg::siz_t             siz,
  input logic [tcb_pkg::adr_w-1:0] adr,
  input logic                      mem_vld,
  input logic [tcb_pkg::ben_w-1:0] mem_ben,
  input tcb_pkg::sts_t             sts
);

  // failed assertions, read by the testbench at the end
  int unsigned fail_cnt;
  // address not a multiple of the size, or wider than the bus
  logic        mis_req;

  assign mis_req = (siz == tcb_pkg::siz_dbl) || ((int'(adr) % (1 << int'(siz))) != 0);

  // misaligned requests never reach the RAM
  a_mal_blocked : assert property (@(posedge sub) disable iff (!arst_n)
    !(mem_vld && mis_req)
  ) else begin
    $error("misaligned request reached the RAM");
    fail_cnt++;
  end

  // a request reaching the RAM enables one lane per byte, never none
  a_ben_used : assert property (@(posedge sub) disable iff (!arst_n)
    mem_vld |-> ($countones(mem_ben) == (1 << siz))
  ) else begin
    $error("byte enables do not match the access size");
    fail_cnt++;
  end

  // status follows a misaligned transfer by one cycle
  a_mal_sts : assert property (@(posedge sub) disable iff (!arst_n)
    (mem_vld_raw && mis_req) |=> (sts == tcb_pkg::sts_mal)
  ) else begin
    $error("misaligned transfer without error status");
    fail_cnt++;
  end

endmodule

// converter outputs, guard strobe and status side by side
bind tcb_riscv_mem_top tcb_riscv_mem_props i_mem_props (
  .sub         (sub),
  .arst_n      (arst_n),
  .mem_vld_raw (mem_vld_raw),
  .siz         (siz),
  .adr         (adr),
  .mem_vld     (mem_vld),
  .mem_ben     (mem_ben),
  .sts         (sts)
);

// ==== tests/tcb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// free running testbench clock, period 40 time units
//////////////////////////////////////////////////////////////////////

module tcb_clk_gen (
  output logic sub
);

  // low for the first half period
  initial begin
    sub = 1'b0;
    forever #20 sub = ~sub;
  end

endmodule

// ==== src/tcb_riscv_mem_top.sv ====
//////////////////////////////////////////////////////////////////////
// load/store port in front of a byte addressable word RAM
// converter steers lanes, guard rejects misaligned accesses,
// RAM answers reads after one cycle together with the status
//////////////////////////////////////////////////////////////////////

module tcb_riscv_mem_top (
  input  logic                      sub,
  input  logic                      arst_n,
  // request
  input  logic                      vld,
  input  logic                      wen,
  input  logic                      uns,
  input  tcb_pkg::ndn_t             ndn,
  input  tcb_pkg::siz_t             siz,
  input  logic [tcb_pkg::adr_w-1:0] adr,
  input  logic [tcb_pkg::dat_w-1:0] wdt,
  // response
  output logic [tcb_pkg::dat_w-1:0] rdt,
  output tcb_pkg::sts_t             sts
);

  // converter to guard
  logic                      mal;
  logic                      mem_vld_raw;
  // guard to RAM
  logic                      mem_vld;
  // converter to RAM and back
  logic                      mem_wen;
  logic [tcb_pkg::adr_w-1:0] mem_adr;
  logic [tcb_pkg::ben_w-1:0] mem_ben;
  logic [tcb_pkg::dat_w-1:0] mem_wdt;
  logic [tcb_pkg::dat_w-1:0] mem_rdt;

  tcb_lib_riscv2memory i_conv (
    .sub         (sub),
    .arst_n      (arst_n),
    .vld         (vld),
    .wen         (wen),
    .uns         (uns),
    .ndn         (ndn),
    .siz         (siz),
    .adr         (adr),
    .wdt         (wdt),
    .rdt         (rdt),
    .mal         (mal),
    .mem_vld_raw (mem_vld_raw),
    .mem_wen     (mem_wen),
    .mem_adr     (mem_adr),
    .mem_ben     (mem_ben),
    .mem_wdt     (mem_wdt),
    .mem_rdt     (mem_rdt)
  );

  tcb_mal_guard i_guard (
    .sub         (sub),
    .arst_n      (arst_n),
    .mem_vld_raw (mem_vld_raw),
    .mal         (mal),
    .mem_vld     (mem_vld),
    .sts         (sts)
  );

  tcb_mem_sram i_sram (
    .sub     (sub),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

endmodule

// ==== src/tcb_mem_sram.sv ====
//////////////////////////////////////////////////////////////////////
// single port word RAM with per-lane write enables
// writes land at the clock edge of the transfer, reads return the
// full word one cycle later from an output register
// contents start cleared, there is no reset
//////////////////////////////////////////////////////////////////////

module tcb_mem_sram (
  input  logic                      sub,
  // request
  input  logic                      mem_vld,
  input  logic                      mem_wen,
  input  logic [tcb_pkg::adr_w-1:0] mem_adr,
  input  logic [tcb_pkg::ben_w-1:0] mem_ben,
  input  logic [tcb_pkg::dat_w-1:0] mem_wdt,
  // response
  output logic [tcb_pkg::dat_w-1:0] mem_rdt
);

  // storage, one word per entry, split into lanes
  logic [tcb_pkg::ben_w-1:0][tcb_pkg::unt_w-1:0] mem [tcb_pkg::mem_depth];

  // word index and lane view of the write data
  logic [tcb_pkg::adr_w-tcb_pkg::alw-1:0]        idx;
  logic [tcb_pkg::ben_w-1:0][tcb_pkg::unt_w-1:0] wdt_b;

  assign idx   = mem_adr[tcb_pkg::adr_w-1:tcb_pkg::alw];
  assign wdt_b = mem_wdt;

  // start from a known, all zero image
  initial begin
    for (int w = 0; w < tcb_pkg::mem_depth; w++) begin
      mem[w] = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // only enabled lanes change
  always_ff @(posedge sub) begin
    if (mem_vld && mem_wen) begin
      for (int i = 0; i < tcb_pkg::ben_w; i++) begin
        if (mem_ben[i]) begin
          mem[idx][i] <= wdt_b[i];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // whole word, lane selection is done upstream
  // output holds between reads
  always_ff @(posedge sub) begin
    if (mem_vld && !mem_wen) begin
      mem_rdt <= mem[idx];
    end
  end

endmodule

// ==== src/tcb_mal_guard.sv ====
//////////////////////////////////////////////////////////////////////
// misalignment guard between the converter and the RAM
// masks the memory strobe for misaligned requests so they never
// touch memory, and returns their status in the response cycle
//////////////////////////////////////////////////////////////////////

module tcb_mal_guard (
  input  logic          sub,
  input  logic          arst_n,
  // from the converter
  input  logic          mem_vld_raw,
  input  logic          mal,
  // to the RAM
  output logic          mem_vld,
  // response status
  output tcb_pkg::sts_t sts
);

  //////////////////////////////////////////////////////////////////////
  // request gating
  //////////////////////////////////////////////////////////////////////

  // only aligned requests reach memory
  assign mem_vld = mem_vld_raw & ~mal;

  //////////////////////////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////////////////////////

  // one cycle behind the transfer, same as read data
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      sts <= tcb_pkg::sts_ok;
    end else if (mem_vld_raw) begin
      // status follows the decode at the transfer
      if (mal) begin
        sts <= tcb_pkg::sts_mal;
      end else begin
        sts <= tcb_pkg::sts_ok;
      end
    end
  end

endmodule

// ==== src/tcb_lib_riscv2memory.sv ====
//////////////////////////////////////////////////////////////////////
// converts RISC-V style size/offset requests into word accesses
// with byte enables and lane-steered write data
// read data comes back one cycle later and is re-ordered and
// sign or zero extended using selects captured at the transfer
// mal flags accesses the guard must keep away from memory
//////////////////////////////////////////////////////////////////////

module tcb_lib_riscv2memory (
  input  logic                        sub,
  input  logic                        arst_n,
  // request side
  input  logic                        vld,
  input  logic                        wen,
  input  logic                        uns,
  input  tcb_pkg::ndn_t               ndn,
  input  tcb_pkg::siz_t               siz,
  input  logic [tcb_pkg::adr_w-1:0]   adr,
  input  logic [tcb_pkg::dat_w-1:0]   wdt,
  output logic [tcb_pkg::dat_w-1:0]   rdt,
  // misaligned access
  output logic                        mal,
  // memory side
  output logic                        mem_vld_raw,
  output logic                        mem_wen,
  output logic [tcb_pkg::adr_w-1:0]   mem_adr,
  output logic [tcb_pkg::ben_w-1:0]   mem_ben,
  output logic [tcb_pkg::dat_w-1:0]   mem_wdt,
  input  logic [tcb_pkg::dat_w-1:0]   mem_rdt
);

  // byte offset inside the word
  tcb_pkg::lane_t lane_a;
  // access size in bytes minus one, wraps for dbl
  tcb_pkg::lane_t siz_m1;

  // byte views of the data buses
  logic [tcb_pkg::ben_w-1:0][tcb_pkg::unt_w-1:0] wdt_b;
  logic [tcb_pkg::ben_w-1:0][tcb_pkg::unt_w-1:0] mem_wdt_b;
  logic [tcb_pkg::ben_w-1:0][tcb_pkg::unt_w-1:0] rdt_lane;
  logic [tcb_pkg::ben_w-1:0][tcb_pkg::unt_w-1:0] rdt_b;

  // per lane, which request byte it carries
  tcb_pkg::lane_t [tcb_pkg::ben_w-1:0] wr_sel;
  // per result byte, which lane it comes from
  tcb_pkg::lane_t [tcb_pkg::ben_w-1:0] rd_sel_req;
  logic           [tcb_pkg::ben_w-1:0] rd_msk_req;

  // captured at a read transfer
  tcb_pkg::lane_t [tcb_pkg::ben_w-1:0] rd_sel;
  logic           [tcb_pkg::ben_w-1:0] rd_msk;
  logic                                rd_uns;
  // top bit of the last valid result byte
  logic                                sgn;

  //////////////////////////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////////////////////////

  assign lane_a = adr[tcb_pkg::alw-1:0];

  // size decode and alignment check, same for reads and writes
  always_comb begin
    unique case (siz)
      tcb_pkg::siz_byte: begin
        siz_m1 = 2'd0;
        mal    = 1'b0;
      end
      tcb_pkg::siz_half: begin
        siz_m1 = 2'd1;
        mal    = adr[0];
      end
      tcb_pkg::siz_word: begin
        siz_m1 = 2'd3;
        mal    = |adr[1:0];
      end
      tcb_pkg::siz_dbl: begin
        // no doubleword on a 32 bit path
        siz_m1 = 2'd3;
        mal    = 1'b1;
      end
    endcase
  end

  // handshake and command pass straight through
  assign mem_vld_raw = vld;
  assign mem_wen     = wen;

  // word aligned address
  assign mem_adr = {adr[tcb_pkg::adr_w-1:tcb_pkg::alw], {tcb_pkg::alw{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // lane steering
  //////////////////////////////////////////////////////////////////////

  assign wdt_b = wdt;

  for (genvar i = 0; i < tcb_pkg::ben_w; i++) begin : g_lane
    // write side, indexed by lane
    always_comb begin
      if (ndn == tcb_pkg::ndn_big) begin
        wr_sel[i] = lane_a + siz_m1 - tcb_pkg::lane_t'(i);
      end else begin
        wr_sel[i] = tcb_pkg::lane_t'(i) - lane_a;
      end
      // lane in use when its offset from the start fits the size
      mem_ben[i] = (tcb_pkg::lane_t'(tcb_pkg::lane_t'(i) - lane_a) <= siz_m1);
      mem_wdt_b[i] = mem_ben[i] ? wdt_b[wr_sel[i]] : '0;
    end

    // read side, indexed by result byte
    always_comb begin
      if (ndn == tcb_pkg::ndn_big) begin
        rd_sel_req[i] = lane_a + siz_m1 - tcb_pkg::lane_t'(i);
      end else begin
        rd_sel_req[i] = lane_a + tcb_pkg::lane_t'(i);
      end
      rd_msk_req[i] = (tcb_pkg::lane_t'(i) <= siz_m1);
    end
  end : g_lane

  assign mem_wdt = mem_wdt_b;

  //////////////////////////////////////////////////////////////////////
  // read response
  //////////////////////////////////////////////////////////////////////

  // hold the read layout for the cycle the RAM answers
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      rd_sel <= '0;
      rd_msk <= '0;
      rd_uns <= 1'b0;
    end else if (vld && !wen) begin
      rd_sel <= rd_sel_req;
      rd_msk <= rd_msk_req;
      rd_uns <= uns;
    end
  end

  assign rdt_lane = mem_rdt;

  // highest used result byte wins
  always_comb begin
    sgn = 1'b0;
    for (int k = 0; k < tcb_pkg::ben_w; k++) begin
      if (rd_msk[k]) begin
        sgn = rdt_lane[rd_sel[k]][tcb_pkg::unt_w-1];
      end
    end
  end

  // re-order lanes, fill the rest with sign or zero
  for (genvar k = 0; k < tcb_pkg::ben_w; k++) begin : g_rsp
    always_comb begin
      if (rd_msk[k]) begin
        rdt_b[k] = rdt_lane[rd_sel[k]];
      end else begin
        rdt_b[k] = rd_uns ? '0 : {tcb_pkg::unt_w{sgn}};
      end
    end
  end : g_rsp

  assign rdt = rdt_b;

endmodule

// ==== src/tcb_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared widths and encodings for the load/store memory subsystem
// every block refers to these by scoped name (tcb_pkg::name)
// sizes and byte order follow the RISC-V load/store conventions
//////////////////////////////////////////////////////////////////////

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // byte address, 4 KiB space
  localparam int unsigned adr_w = 12;
  // data bus
  localparam int unsigned dat_w = 32;
  // byte lanes per word
  localparam int unsigned ben_w = 4;
  // bits per lane
  localparam int unsigned unt_w = 8;
  // low address bits dropped for a word address
  localparam int unsigned alw = 2;
  // words in the RAM
  localparam int unsigned mem_depth = 1024;

  // lane index, also the in-word byte offset
  typedef logic [alw-1:0] lane_t;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // access size, log2 of bytes
  typedef enum logic [1:0] {
    siz_byte = 2'd0,
    siz_half = 2'd1,
    siz_word = 2'd2,
    // wider than the bus, always rejected
    siz_dbl  = 2'd3
  } siz_t;

  // byte order of the request data
  typedef enum logic {
    ndn_little = 1'b0,
    ndn_big    = 1'b1
  } ndn_t;

  // response status
  typedef enum logic {
    sts_ok  = 1'b0,
    sts_mal = 1'b1
  } sts_t;

endpackage
